// ==== src/sys_macros.svh ====
/*
 * System register bus and video timing constants
 * Bus widths, address field positions, block numbers and TFT defaults
 */
`ifndef SYS_MACROS_SVH
`define SYS_MACROS_SVH

// --------------------------------------------------
// Bus widths and address fields
// --------------------------------------------------
`define USI_DATA_WIDTH      32
`define BUS_ADRS_WIDTH      32
`define BLOCK_ADRS_WIDTH    4
`define BLOCK_ADRS_LSB      16
`define CSR_ADRS_WIDTH      16
`define CSR_ADRS_LSB        0

// Block numbers on the register bus
`define BLK_GPIO            4'd1
`define BLK_VIDEO           4'd4

// GPIO field width
`define LED_WIDTH           2

// --------------------------------------------------
// Video register widths and default timing
// --------------------------------------------------
`define H_DISPLAY_WIDTH     11
`define H_PORCH_WIDTH       7
`define V_DISPLAY_WIDTH     11
`define V_PORCH_WIDTH       5
`define COLOR_WIDTH         4

// 480x272 panel
`define H_DISPLAY_DEFAULT   480
`define H_FRONT_DEFAULT     8
`define H_BACK_DEFAULT      43
`define H_PULSE_DEFAULT     30
`define V_DISPLAY_DEFAULT   272
`define V_FRONT_DEFAULT     12
`define V_BACK_DEFAULT      4
`define V_PULSE_DEFAULT     10

`endif

// ==== src/sysPkg.sv ====
/*
 * System package
 * Block numbers, register offsets, sync phases and the video timing set
 */
`include "sys_macros.svh"

package sysPkg;

	// Block field of the bus address
	typedef enum logic [`BLOCK_ADRS_WIDTH-1:0]
	{
		blkGpio  = `BLK_GPIO,
		blkVideo = `BLK_VIDEO
	} blockIdE;

	// GPIO register offsets
	typedef enum logic [`CSR_ADRS_WIDTH-1:0]
	{
		gpioLed = 'd0,
		gpioRgb = 'd1
	} gpioRegE;

	// Video register offsets
	typedef enum logic [`CSR_ADRS_WIDTH-1:0]
	{
		vidCtrl     = 'd0,
		vidHDisplay = 'd1,
		vidHFront   = 'd2,
		vidHBack    = 'd3,
		vidHPulse   = 'd4,
		vidVDisplay = 'd5,
		vidVFront   = 'd6,
		vidVBack    = 'd7,
		vidVPulse   = 'd8,
		vidFill     = 'd9
	} videoRegE;

	// Position within a line or a frame
	typedef enum logic [1:0]
	{
		phPulse,
		phBack,
		phActive,
		phFront
	} syncPhaseE;

	// Fill colour is R in the top nibble, then G, then B
	typedef struct packed
	{
		logic [`H_DISPLAY_WIDTH-1:0]  hDisplay;
		logic [`H_PORCH_WIDTH-1:0]    hFront;
		logic [`H_PORCH_WIDTH-1:0]    hBack;
		logic [`H_PORCH_WIDTH-1:0]    hPulse;
		logic [`V_DISPLAY_WIDTH-1:0]  vDisplay;
		logic [`V_PORCH_WIDTH-1:0]    vFront;
		logic [`V_PORCH_WIDTH-1:0]    vBack;
		logic [`V_PORCH_WIDTH-1:0]    vPulse;
		logic                         enable;
		logic [3*`COLOR_WIDTH-1:0]    fill;
	} videoTimingT;

endpackage

// ==== src/usiBusIf.sv ====
/*
 * Register bus link from the bus core to one slave block
 * Carries the qualified strobes, write data and offset, and the read return
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

interface usiBusIf;

	logic [`USI_DATA_WIDTH-1:0] wd;
	logic [`CSR_ADRS_WIDTH-1:0] offset;
	logic                       wEd;
	logic                       rEd;
	logic [`USI_DATA_WIDTH-1:0] rd;
	logic                       rdValid;

	modport master (output wd, offset, wEd, rEd, input rd, rdValid);

	// Slave sees only its own offset, never the block field
	modport slave (input wd, offset, wEd, rEd, output rd, rdValid);

endinterface

// ==== src/usiBus.sv ====
/*
 * Register bus core
 * Registers each master request, decodes the block field into one slave
 * strobe and merges the slave returns. Reads of unmapped blocks get a
 * zero result with the same latency as a mapped read.
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module usiBus
(
	input  logic                       iSysClk,
	input  logic                       rstN,
	input  logic [`BUS_ADRS_WIDTH-1:0] busAdrs,
	input  logic [`USI_DATA_WIDTH-1:0] busWd,
	input  logic                       busWEd,
	input  logic                       busREd,
	output logic [`USI_DATA_WIDTH-1:0] busRd,
	output logic                       busRdValid,
	usiBusIf.master                    gpioBus,
	usiBusIf.master                    videoBus
);

	logic [`BLOCK_ADRS_WIDTH-1:0] reqBlock;
	logic [`CSR_ADRS_WIDTH-1:0]   reqOffset;
	logic [`USI_DATA_WIDTH-1:0]   reqWd;
	logic                         reqWEd;
	logic                         reqREd;
	logic                         hitGpio;
	logic                         hitVideo;
	logic                         unmappedRdValid;

	// --------------------------------------------------
	// Request register
	// --------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			reqWEd <= 1'b0;
			reqREd <= 1'b0;
		end
		else
		begin
			reqWEd <= busWEd;
			// Write wins over a read in the same cycle
			reqREd <= busREd & ~busWEd;
		end
	end

	always_ff @(posedge iSysClk)
	begin
		reqBlock  <= busAdrs[`BLOCK_ADRS_LSB +: `BLOCK_ADRS_WIDTH];
		reqOffset <= busAdrs[`CSR_ADRS_LSB +: `CSR_ADRS_WIDTH];
		reqWd     <= busWd;
	end

	// --------------------------------------------------
	// Block decode and slave strobes
	// --------------------------------------------------
	assign hitGpio  = (reqBlock == sysPkg::blkGpio);
	assign hitVideo = (reqBlock == sysPkg::blkVideo);

	assign gpioBus.wd      = reqWd;
	assign gpioBus.offset  = reqOffset;
	assign gpioBus.wEd     = reqWEd & hitGpio;
	assign gpioBus.rEd     = reqREd & hitGpio;

	assign videoBus.wd     = reqWd;
	assign videoBus.offset = reqOffset;
	assign videoBus.wEd    = reqWEd & hitVideo;
	assign videoBus.rEd    = reqREd & hitVideo;

	// Stand in for a slave on unmapped reads, one cycle later like a slave
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			unmappedRdValid <= 1'b0;
		else
			unmappedRdValid <= reqREd & ~(hitGpio | hitVideo);
	end

	// Idle slaves return zero, so an OR is enough to merge
	assign busRd      = gpioBus.rd | videoBus.rd;
	assign busRdValid = gpioBus.rdValid | videoBus.rdValid | unmappedRdValid;

endmodule

// ==== src/gpioCsr.sv ====
/*
 * GPIO register block
 * Two LED bits and an RGB LED, both readable over the register bus
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module gpioCsr
(
	input  logic                  iSysClk,
	input  logic                  rstN,
	usiBusIf.slave                bus,
	output logic [`LED_WIDTH-1:0] led,
	output logic                  ledR,
	output logic                  ledG,
	output logic                  ledB
);

	logic [`LED_WIDTH-1:0]      ledReg;
	// R, G, B from bit 2 down
	logic [2:0]                 rgbReg;
	logic [`USI_DATA_WIDTH-1:0] rdData;

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			ledReg <= '0;
			rgbReg <= '0;
		end
		else if (bus.wEd)
		begin
			case (bus.offset)
				sysPkg::gpioLed: ledReg <= bus.wd[`LED_WIDTH-1:0];
				sysPkg::gpioRgb: rgbReg <= bus.wd[2:0];
				default: ;
			endcase
		end
	end

	// Readback, upper bits read as zero
	always_comb
	begin
		rdData = '0;
		case (bus.offset)
			sysPkg::gpioLed: rdData[`LED_WIDTH-1:0] = ledReg;
			sysPkg::gpioRgb: rdData[2:0] = rgbReg;
			default: ;
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			bus.rdValid <= 1'b0;
			bus.rd      <= '0;
		end
		else
		begin
			bus.rdValid <= bus.rEd;
			bus.rd      <= bus.rEd ? rdData : '0;
		end
	end

	assign led  = ledReg;
	assign ledR = rgbReg[2];
	assign ledG = rgbReg[1];
	assign ledB = rgbReg[0];

endmodule

// ==== src/videoCsr.sv ====
/*
 * Video transmit register block
 * TFT timing, enable, backlight and fill colour, readable over the bus
 * and presented to the timing generator as one timing set
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module videoCsr
(
	input  logic               iSysClk,
	input  logic               rstN,
	usiBusIf.slave             bus,
	output sysPkg::videoTimingT timing,
	output logic               tftBackLight
);

	sysPkg::videoTimingT        timingReg;
	logic                       backLight;
	logic [`USI_DATA_WIDTH-1:0] rdData;

	// --------------------------------------------------
	// Register writes
	// --------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			timingReg.hDisplay <= `H_DISPLAY_DEFAULT;
			timingReg.hFront   <= `H_FRONT_DEFAULT;
			timingReg.hBack    <= `H_BACK_DEFAULT;
			timingReg.hPulse   <= `H_PULSE_DEFAULT;
			timingReg.vDisplay <= `V_DISPLAY_DEFAULT;
			timingReg.vFront   <= `V_FRONT_DEFAULT;
			timingReg.vBack    <= `V_BACK_DEFAULT;
			timingReg.vPulse   <= `V_PULSE_DEFAULT;
			timingReg.enable   <= 1'b0;
			timingReg.fill     <= '0;
			backLight          <= 1'b0;
		end
		else if (bus.wEd)
		begin
			case (bus.offset)
				sysPkg::vidCtrl:
				begin
					timingReg.enable <= bus.wd[0];
					backLight        <= bus.wd[1];
				end
				sysPkg::vidHDisplay: timingReg.hDisplay <= bus.wd[`H_DISPLAY_WIDTH-1:0];
				sysPkg::vidHFront:   timingReg.hFront   <= bus.wd[`H_PORCH_WIDTH-1:0];
				sysPkg::vidHBack:    timingReg.hBack    <= bus.wd[`H_PORCH_WIDTH-1:0];
				sysPkg::vidHPulse:   timingReg.hPulse   <= bus.wd[`H_PORCH_WIDTH-1:0];
				sysPkg::vidVDisplay: timingReg.vDisplay <= bus.wd[`V_DISPLAY_WIDTH-1:0];
				sysPkg::vidVFront:   timingReg.vFront   <= bus.wd[`V_PORCH_WIDTH-1:0];
				sysPkg::vidVBack:    timingReg.vBack    <= bus.wd[`V_PORCH_WIDTH-1:0];
				sysPkg::vidVPulse:   timingReg.vPulse   <= bus.wd[`V_PORCH_WIDTH-1:0];
				sysPkg::vidFill:     timingReg.fill     <= bus.wd[3*`COLOR_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	// --------------------------------------------------
	// Readback
	// --------------------------------------------------
	always_comb
	begin
		rdData = '0;
		case (bus.offset)
			sysPkg::vidCtrl:     rdData[1:0] = {backLight, timingReg.enable};
			sysPkg::vidHDisplay: rdData[`H_DISPLAY_WIDTH-1:0] = timingReg.hDisplay;
			sysPkg::vidHFront:   rdData[`H_PORCH_WIDTH-1:0] = timingReg.hFront;
			sysPkg::vidHBack:    rdData[`H_PORCH_WIDTH-1:0] = timingReg.hBack;
			sysPkg::vidHPulse:   rdData[`H_PORCH_WIDTH-1:0] = timingReg.hPulse;
			sysPkg::vidVDisplay: rdData[`V_DISPLAY_WIDTH-1:0] = timingReg.vDisplay;
			sysPkg::vidVFront:   rdData[`V_PORCH_WIDTH-1:0] = timingReg.vFront;
			sysPkg::vidVBack:    rdData[`V_PORCH_WIDTH-1:0] = timingReg.vBack;
			sysPkg::vidVPulse:   rdData[`V_PORCH_WIDTH-1:0] = timingReg.vPulse;
			sysPkg::vidFill:     rdData[3*`COLOR_WIDTH-1:0] = timingReg.fill;
			default: ;
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			bus.rdValid <= 1'b0;
			bus.rd      <= '0;
		end
		else
		begin
			bus.rdValid <= bus.rEd;
			bus.rd      <= bus.rEd ? rdData : '0;
		end
	end

	assign timing       = timingReg;
	assign tftBackLight = backLight;

endmodule

// ==== src/videoTiming.sv ====
/*
 * TFT timing generator
 * Horizontal and vertical phase counters give hsync, vsync, data enable
 * and a fill colour, one pixel per system clock
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module videoTiming
(
	input  logic                    iSysClk,
	input  logic                    rstN,
	input  sysPkg::videoTimingT     timing,
	output logic                    tftHSync,
	output logic                    tftVSync,
	output logic                    tftDe,
	output logic [`COLOR_WIDTH-1:0] tftColorR,
	output logic [`COLOR_WIDTH-1:0] tftColorG,
	output logic [`COLOR_WIDTH-1:0] tftColorB
);

	localparam int hCntW = `H_DISPLAY_WIDTH;
	localparam int vCntW = `V_DISPLAY_WIDTH;

	sysPkg::syncPhaseE         hPhase;
	sysPkg::syncPhaseE         vPhase;
	logic [hCntW-1:0]          hCount;
	logic [vCntW-1:0]          vCount;
	logic                      running;
	logic                      active;
	logic                      hLast;
	logic                      vLast;
	logic                      lineEnd;
	logic                      deNext;
	logic [3*`COLOR_WIDTH-1:0] colorQ;

	assign active  = running & timing.enable;
	assign hLast   = (hCount == hCntW'(1));
	assign vLast   = (vCount == vCntW'(1));
	assign lineEnd = (hPhase == sysPkg::phFront) && hLast;

	// --------------------------------------------------
	// Horizontal phase, restarts at pixel 0 on enable
	// --------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			running <= 1'b0;
			hPhase  <= sysPkg::phPulse;
			hCount  <= '0;
		end
		else if (!timing.enable)
			running <= 1'b0;
		else if (!running)
		begin
			running <= 1'b1;
			hPhase  <= sysPkg::phPulse;
			hCount  <= hCntW'(timing.hPulse);
		end
		else if (hLast)
		begin
			case (hPhase)
				sysPkg::phPulse:
				begin
					hPhase <= sysPkg::phBack;
					hCount <= hCntW'(timing.hBack);
				end
				sysPkg::phBack:
				begin
					hPhase <= sysPkg::phActive;
					hCount <= timing.hDisplay;
				end
				sysPkg::phActive:
				begin
					hPhase <= sysPkg::phFront;
					hCount <= hCntW'(timing.hFront);
				end
				sysPkg::phFront:
				begin
					hPhase <= sysPkg::phPulse;
					hCount <= hCntW'(timing.hPulse);
				end
			endcase
		end
		else
			hCount <= hCount - 1'b1;
	end

	// Vertical phase counts lines, steps at the end of each front porch
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			vPhase <= sysPkg::phPulse;
			vCount <= '0;
		end
		else if (timing.enable && !running)
		begin
			vPhase <= sysPkg::phPulse;
			vCount <= vCntW'(timing.vPulse);
		end
		else if (active && lineEnd)
		begin
			if (vLast)
			begin
				case (vPhase)
					sysPkg::phPulse:
					begin
						vPhase <= sysPkg::phBack;
						vCount <= vCntW'(timing.vBack);
					end
					sysPkg::phBack:
					begin
						vPhase <= sysPkg::phActive;
						vCount <= timing.vDisplay;
					end
					sysPkg::phActive:
					begin
						vPhase <= sysPkg::phFront;
						vCount <= vCntW'(timing.vFront);
					end
					sysPkg::phFront:
					begin
						vPhase <= sysPkg::phPulse;
						vCount <= vCntW'(timing.vPulse);
					end
				endcase
			end
			else
				vCount <= vCount - 1'b1;
		end
	end

	// --------------------------------------------------
	// Output register, syncs are active low
	// --------------------------------------------------
	assign deNext = active && (hPhase == sysPkg::phActive) && (vPhase == sysPkg::phActive);

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			tftHSync <= 1'b1;
			tftVSync <= 1'b1;
			tftDe    <= 1'b0;
			colorQ   <= '0;
		end
		else
		begin
			tftHSync <= !(active && (hPhase == sysPkg::phPulse));
			tftVSync <= !(active && (vPhase == sysPkg::phPulse));
			tftDe    <= deNext;
			colorQ   <= deNext ? timing.fill : '0;
		end
	end

	assign tftColorR = colorQ[3*`COLOR_WIDTH-1 -: `COLOR_WIDTH];
	assign tftColorG = colorQ[2*`COLOR_WIDTH-1 -: `COLOR_WIDTH];
	assign tftColorB = colorQ[`COLOR_WIDTH-1:0];

endmodule

// ==== src/sysTop.sv ====
/*
 * System top
 * External bus master port to the register bus, GPIO block and
 * video transmit block with its timing generator
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module sysTop
(
	input  logic                       iSysClk,
	input  logic                       rstN,
	input  logic [`BUS_ADRS_WIDTH-1:0] busAdrs,
	input  logic [`USI_DATA_WIDTH-1:0] busWd,
	input  logic                       busWEd,
	input  logic                       busREd,
	output logic [`USI_DATA_WIDTH-1:0] busRd,
	output logic                       busRdValid,
	output logic [`LED_WIDTH-1:0]      led,
	output logic                       ledR,
	output logic                       ledG,
	output logic                       ledB,
	output logic [`COLOR_WIDTH-1:0]    tftColorR,
	output logic [`COLOR_WIDTH-1:0]    tftColorG,
	output logic [`COLOR_WIDTH-1:0]    tftColorB,
	output logic                       tftHSync,
	output logic                       tftVSync,
	output logic                       tftDe,
	output logic                       tftBackLight
);

	usiBusIf             gpioBus ();
	usiBusIf             videoBus ();
	sysPkg::videoTimingT timing;

	// --------------------------------------------------
	// Register bus
	// --------------------------------------------------
	usiBus busCore (
		.iSysClk    (iSysClk),
		.rstN       (rstN),
		.busAdrs    (busAdrs),
		.busWd      (busWd),
		.busWEd     (busWEd),
		.busREd     (busREd),
		.busRd      (busRd),
		.busRdValid (busRdValid),
		.gpioBus    (gpioBus.master),
		.videoBus   (videoBus.master)
	);

	// Block 1
	gpioCsr gpioRegs (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.bus     (gpioBus.slave),
		.led     (led),
		.ledR    (ledR),
		.ledG    (ledG),
		.ledB    (ledB)
	);

	// --------------------------------------------------
	// Video transmit, block 4
	// --------------------------------------------------
	videoCsr videoRegs (
		.iSysClk      (iSysClk),
		.rstN         (rstN),
		.bus          (videoBus.slave),
		.timing       (timing),
		.tftBackLight (tftBackLight)
	);

	videoTiming videoGen (
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.timing    (timing),
		.tftHSync  (tftHSync),
		.tftVSync  (tftVSync),
		.tftDe     (tftDe),
		.tftColorR (tftColorR),
		.tftColorG (tftColorG),
		.tftColorB (tftColorB)
	);

endmodule

// ==== sim/tbSysTop.sv ====
/*
 * System top testbench
 * Register bus reads and writes against a shadow map, GPIO pins,
 * unmapped accesses and TFT frame timing of the video block
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module tbSysTop;

	typedef struct
	{
		logic [`USI_DATA_WIDTH-1:0] data;
		int                         cyc;
	} readExpT;

	typedef struct
	{
		int lineLen;
		int frameLen;
		int deCount;
		int vSyncLow;
	} frameCountsT;

	// Small frame for the timing test
	localparam int tHPulse = 3;
	localparam int tHBack = 2;
	localparam int tHDisplay = 8;
	localparam int tHFront = 2;
	localparam int tVPulse = 2;
	localparam int tVBack = 1;
	localparam int tVDisplay = 4;
	localparam int tVFront = 1;
	localparam int testFrameLen = (tHPulse + tHBack + tHDisplay + tHFront)
		* (tVPulse + tVBack + tVDisplay + tVFront);

	// Read result is seen at the negedge three edges after the drive edge
	localparam int rdLatency = 3;
	localparam int gpioWrites = 24;
	localparam int videoRounds = 2;
	localparam int testCount = gpioWrites + videoRounds * 10 + 40;
	localparam int watchdogCycles = testCount * 16 + 2 * testFrameLen * 3;

	logic                       iSysClk;
	logic                       rstN;
	logic [`BUS_ADRS_WIDTH-1:0] busAdrs;
	logic [`USI_DATA_WIDTH-1:0] busWd;
	logic                       busWEd;
	logic                       busREd;
	logic [`USI_DATA_WIDTH-1:0] busRd;
	logic                       busRdValid;
	logic [`LED_WIDTH-1:0]      led;
	logic                       ledR;
	logic                       ledG;
	logic                       ledB;
	logic [`COLOR_WIDTH-1:0]    tftColorR;
	logic [`COLOR_WIDTH-1:0]    tftColorG;
	logic [`COLOR_WIDTH-1:0]    tftColorB;
	logic                       tftHSync;
	logic                       tftVSync;
	logic                       tftDe;
	logic                       tftBackLight;

	logic [15:0]                lfsrState = 16'd45615;
	logic [`USI_DATA_WIDTH-1:0] shadow [logic [19:0]];
	readExpT                    expQ [$];
	int                         cycle = 0;
	sysPkg::videoTimingT        testTiming;

	sysTop UUT (.*);

	initial
	begin
		iSysClk = 1'b0;
		forever #10 iSysClk = ~iSysClk;
	end

	always @(posedge iSysClk)
		cycle <= cycle + 1;

	// --------------------------------------------------
	// Reference model and random data
	// --------------------------------------------------
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
		end
		return r;
	endfunction

	// Stored bits per register, zero where nothing is mapped
	function automatic logic [31:0] fieldMask(input logic [3:0] blk, input logic [15:0] off);
		logic [31:0] m;
		m = '0;
		if (blk == sysPkg::blkGpio)
		begin
			if (off == sysPkg::gpioLed)
				m = (32'd1 << `LED_WIDTH) - 1;
			else if (off == sysPkg::gpioRgb)
				m = 32'h7;
		end
		else if (blk == sysPkg::blkVideo)
		begin
			case (off)
				sysPkg::vidCtrl: m = 32'h3;
				sysPkg::vidHDisplay: m = (32'd1 << `H_DISPLAY_WIDTH) - 1;
				sysPkg::vidVDisplay: m = (32'd1 << `V_DISPLAY_WIDTH) - 1;
				sysPkg::vidHFront, sysPkg::vidHBack, sysPkg::vidHPulse:
					m = (32'd1 << `H_PORCH_WIDTH) - 1;
				sysPkg::vidVFront, sysPkg::vidVBack, sysPkg::vidVPulse:
					m = (32'd1 << `V_PORCH_WIDTH) - 1;
				sysPkg::vidFill: m = (32'd1 << (3 * `COLOR_WIDTH)) - 1;
				default: m = '0;
			endcase
		end
		return m;
	endfunction

	function automatic void refWrite(input logic [3:0] blk, input logic [15:0] off,
		input logic [31:0] data);
		if (fieldMask(blk, off) != 0)
			shadow[{blk, off}] = data & fieldMask(blk, off);
	endfunction

	function automatic logic [31:0] refRead(input logic [3:0] blk, input logic [15:0] off);
		if (shadow.exists({blk, off}))
			return shadow[{blk, off}];
		return '0;
	endfunction

	function automatic frameCountsT frameRef(input sysPkg::videoTimingT t);
		frameCountsT c;
		c.lineLen  = int'(t.hPulse) + int'(t.hBack) + int'(t.hDisplay) + int'(t.hFront);
		c.frameLen = c.lineLen * (int'(t.vPulse) + int'(t.vBack) + int'(t.vDisplay)
			+ int'(t.vFront));
		c.deCount  = int'(t.hDisplay) * int'(t.vDisplay);
		c.vSyncLow = int'(t.vPulse) * c.lineLen;
		return c;
	endfunction

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkWord(input logic [`USI_DATA_WIDTH-1:0] got,
		input logic [`USI_DATA_WIDTH-1:0] exp, input string what);
		if (got !== exp)
			failRun($sformatf("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkCounts(input frameCountsT got, input frameCountsT exp);
		if (got.lineLen != exp.lineLen || got.frameLen != exp.frameLen
			|| got.deCount != exp.deCount || got.vSyncLow != exp.vSyncLow)
			failRun($sformatf("ERROR at %0t: frame line %0d frame %0d de %0d vsync %0d, %s",
				$time, got.lineLen, got.frameLen, got.deCount, got.vSyncLow,
				$sformatf("expected %0d %0d %0d %0d", exp.lineLen, exp.frameLen,
				exp.deCount, exp.vSyncLow)));
	endtask

	// In-order read return, one result per strobe
	always @(negedge iSysClk)
	begin
		readExpT e;
		if (rstN && busRdValid)
		begin
			if (expQ.size() == 0)
				failRun("Read data came back with no read outstanding");
			else
			begin
				e = expQ.pop_front();
				checkWord(32'(cycle), 32'(e.cyc), "read return cycle");
				checkWord(busRd, e.data, "read data");
			end
		end
		else if (expQ.size() != 0 && expQ[0].cyc <= cycle)
			failRun("A read got no valid result at its expected cycle");
	end

	// --------------------------------------------------
	// Bus driver tasks
	// --------------------------------------------------
	task automatic busWrite(input logic [3:0] blk, input logic [15:0] off,
		input logic [31:0] data);
		@(posedge iSysClk);
		busAdrs <= {12'h000, blk, off};
		busWd   <= data;
		busWEd  <= 1'b1;
		busREd  <= 1'b0;
		@(posedge iSysClk);
		busWEd  <= 1'b0;
		refWrite(blk, off, data);
	endtask

	task automatic issueRead(input logic [3:0] blk, input logic [15:0] off);
		readExpT e;
		@(posedge iSysClk);
		busAdrs <= {12'h000, blk, off};
		busWEd  <= 1'b0;
		busREd  <= 1'b1;
		e.data = refRead(blk, off);
		e.cyc  = cycle + rdLatency;
		expQ.push_back(e);
	endtask

	task automatic endReads;
		@(posedge iSysClk);
		busREd <= 1'b0;
		while (expQ.size() != 0)
			@(negedge iSysClk);
	endtask

	task automatic readAllMapped;
		int i;
		for (i = 0; i < 2; i++)
			issueRead(sysPkg::blkGpio, 16'(i));
		for (i = 0; i < 10; i++)
			issueRead(sysPkg::blkVideo, 16'(i));
		endReads();
	endtask

	// Pins against the model, in the cycle right after the register update
	task automatic checkPins;
		logic [31:0] ledExp;
		logic [31:0] rgbExp;
		logic [31:0] ctrlExp;
		@(posedge iSysClk);
		@(negedge iSysClk);
		ledExp  = refRead(sysPkg::blkGpio, sysPkg::gpioLed);
		rgbExp  = refRead(sysPkg::blkGpio, sysPkg::gpioRgb);
		ctrlExp = refRead(sysPkg::blkVideo, sysPkg::vidCtrl);
		checkWord(32'(led), ledExp, "led pins");
		checkWord(32'({ledR, ledG, ledB}), rgbExp, "rgb pins");
		checkWord(32'(tftBackLight), 32'(ctrlExp[1]), "backlight pin");
	endtask

	task automatic checkVideoIdle;
		checkWord(32'({tftHSync, tftVSync, tftDe, tftColorR, tftColorG, tftColorB}),
			32'({2'b11, 1'b0, 12'h000}), "idle video outputs");
	endtask

	// One frame from a vsync fall to the next
	task automatic measureFrame(output frameCountsT got);
		logic prevH;
		logic prevV;
		logic started;
		logic done;
		int   sinceH;
		got = '{default: 0};
		prevH = tftHSync;
		prevV = tftVSync;
		started = 1'b0;
		done = 1'b0;
		sinceH = 0;
		while (!done)
		begin
			@(negedge iSysClk);
			checkWord(32'({tftColorR, tftColorG, tftColorB}),
				tftDe ? 32'(testTiming.fill) : 32'd0, "pixel colour");
			if (started)
			begin
				got.frameLen++;
				if (prevV && !tftVSync)
					done = 1'b1;
				else
				begin
					sinceH++;
					if (prevH && !tftHSync && got.lineLen == 0)
						got.lineLen = sinceH;
					got.deCount += int'(tftDe);
					got.vSyncLow += int'(!tftVSync);
				end
			end
			else if (prevV && !tftVSync)
			begin
				started = 1'b1;
				got.deCount = int'(tftDe);
				got.vSyncLow = 1;
			end
			prevH = tftHSync;
			prevV = tftVSync;
		end
	endtask

	initial
	begin
		repeat (watchdogCycles) @(posedge iSysClk);
		$display("Watchdog ran out after %0d clocks, the run is hung", watchdogCycles);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog timeout");
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		frameCountsT measured;
		logic [15:0] off;
		int          i;
		int          r;
		rstN    = 1'b0;
		busAdrs = '0;
		busWd   = '0;
		busWEd  = 1'b0;
		busREd  = 1'b0;
		refWrite(sysPkg::blkVideo, sysPkg::vidHDisplay, `H_DISPLAY_DEFAULT);
		refWrite(sysPkg::blkVideo, sysPkg::vidHFront, `H_FRONT_DEFAULT);
		refWrite(sysPkg::blkVideo, sysPkg::vidHBack, `H_BACK_DEFAULT);
		refWrite(sysPkg::blkVideo, sysPkg::vidHPulse, `H_PULSE_DEFAULT);
		refWrite(sysPkg::blkVideo, sysPkg::vidVDisplay, `V_DISPLAY_DEFAULT);
		refWrite(sysPkg::blkVideo, sysPkg::vidVFront, `V_FRONT_DEFAULT);
		refWrite(sysPkg::blkVideo, sysPkg::vidVBack, `V_BACK_DEFAULT);
		refWrite(sysPkg::blkVideo, sysPkg::vidVPulse, `V_PULSE_DEFAULT);
		repeat (4) @(posedge iSysClk);
		rstN <= 1'b1;

		// Reset defaults
		@(negedge iSysClk);
		checkVideoIdle();
		checkPins();
		readAllMapped();

		// GPIO registers
		for (i = 0; i < gpioWrites; i++)
		begin
			off = 16'(randBits(1));
			busWrite(sysPkg::blkGpio, off, randBits(32));
			checkPins();
			issueRead(sysPkg::blkGpio, off);
			endReads();
		end

		// Video registers, enable kept off
		for (r = 0; r < videoRounds; r++)
			for (i = 0; i < 10; i++)
			begin
				busWrite(sysPkg::blkVideo, 16'(i), randBits(32) & ~32'h1);
				checkPins();
				issueRead(sysPkg::blkVideo, 16'(i));
				endReads();
			end

		// Unmapped blocks and offsets
		busWrite(4'd2, 16'd0, randBits(32));
		busWrite(4'd15, 16'd1, randBits(32));
		busWrite(sysPkg::blkGpio, 16'd5, randBits(32));
		busWrite(sysPkg::blkVideo, 16'd12, randBits(32));
		for (i = 0; i < 6; i++)
		begin
			issueRead(4'(i * 2 + 3), 16'(randBits(4)));
			issueRead(sysPkg::blkGpio, 16'(2 + randBits(3)));
			issueRead(sysPkg::blkVideo, 16'(10 + randBits(3)));
		end
		endReads();
		readAllMapped();

		// Frame timing
		testTiming = '{hDisplay: tHDisplay, hFront: tHFront, hBack: tHBack, hPulse: tHPulse,
			vDisplay: tVDisplay, vFront: tVFront, vBack: tVBack, vPulse: tVPulse,
			enable: 1'b1, fill: 12'hA5C};
		busWrite(sysPkg::blkVideo, sysPkg::vidHDisplay, 32'(testTiming.hDisplay));
		busWrite(sysPkg::blkVideo, sysPkg::vidHFront, 32'(testTiming.hFront));
		busWrite(sysPkg::blkVideo, sysPkg::vidHBack, 32'(testTiming.hBack));
		busWrite(sysPkg::blkVideo, sysPkg::vidHPulse, 32'(testTiming.hPulse));
		busWrite(sysPkg::blkVideo, sysPkg::vidVDisplay, 32'(testTiming.vDisplay));
		busWrite(sysPkg::blkVideo, sysPkg::vidVFront, 32'(testTiming.vFront));
		busWrite(sysPkg::blkVideo, sysPkg::vidVBack, 32'(testTiming.vBack));
		busWrite(sysPkg::blkVideo, sysPkg::vidVPulse, 32'(testTiming.vPulse));
		busWrite(sysPkg::blkVideo, sysPkg::vidFill, 32'(testTiming.fill));
		busWrite(sysPkg::blkVideo, sysPkg::vidCtrl, 32'h3);
		checkPins();
		measureFrame(measured);
		checkCounts(measured, frameRef(testTiming));
		busWrite(sysPkg::blkVideo, sysPkg::vidCtrl, 32'h2);
		checkPins();
		@(posedge iSysClk);
		@(negedge iSysClk);
		checkVideoIdle();
		readAllMapped();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+src
src/sysPkg.sv
src/usiBusIf.sv
src/usiBus.sv
src/gpioCsr.sv
src/videoCsr.sv
src/videoTiming.sv
src/sysTop.sv
sim/tbSysTop.sv

// ==== Bender.yml ====
package:
  name: sys_top

export_include_dirs:
  - src

sources:
  - src/sysPkg.sv
  - src/usiBusIf.sv
  - src/usiBus.sv
  - src/gpioCsr.sv
  - src/videoCsr.sv
  - src/videoTiming.sv
  - src/sysTop.sv
  - target: simulation
    files:
      - sim/tbSysTop.sv
